// File: project.f
hw/quad_ctrl_pkg.sv
hw/job_sequencer.sv
hw/pfb_reader.sv
hw/pix_seq_reader.sv
hw/output_tracker.sv
hw/quad_ctrl_top.sv
tests/tb_quad_ctrl.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the quad control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_quad_ctrl -o sim_quad
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_quad > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// File: tests/tb_quad_ctrl.sv
`default_nettype none

module tb_quad_ctrl;

    localparam int NUM_JOBS = 4;
    localparam int START_TIMEOUT = 40;
    localparam int JOB_TIMEOUT = 6000;

    logic                                clk;
    logic                                rst;
    logic                                job_start;
    logic                                job_accept;
    quad_ctrl_pkg::job_cfg_t             cfg;
    logic                                fetch_req;
    quad_ctrl_pkg::fetch_resp_t          fetch_resp;
    logic                                job_complete;
    logic                                job_complete_ack;
    logic                                pfb_rden;
    quad_ctrl_pkg::seq_rd_t              seq_rd;
    logic [quad_ctrl_pkg::CE_EXEC_W-1:0] ce_execute;
    logic [1:0]                          gray_code;

    // Job table, sizes as last index, one sequence pass per output row
    quad_ctrl_pkg::coord_t   tab_cols [NUM_JOBS] = '{9'd1, 9'd2, 9'd3, 9'd1};
    quad_ctrl_pkg::coord_t   tab_rows [NUM_JOBS] = '{9'd1, 9'd3, 9'd0, 9'd2};
    quad_ctrl_pkg::seq_cnt_t tab_seq  [NUM_JOBS] = '{11'd10, 11'd15, 11'd20, 11'd10};
    quad_ctrl_pkg::pfb_cnt_t tab_pfb  [NUM_JOBS] = '{9'd3, 9'd4, 9'd6, 9'd2};

    int  errors;
    int  timeouts;
    int  checks;
    bit  timed_out;

    // Monitor state
    int                       acc_run;
    int                       rd_pulses;
    int                       addr_steps;
    int                       exec_pulses;
    int                       gray_step;
    bit                       in_progress;
    logic                     prev_req;
    logic                     prev_ack;
    logic                     prev_done;
    logic                     prev_cack;
    logic [1:0]               prev_gray;
    quad_ctrl_pkg::seq_addr_t prev_addr;
    logic [6:0]               wave_hist;

    quad_ctrl_top UUT (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .job_accept       (job_accept),
        .cfg              (cfg),
        .fetch_req        (fetch_req),
        .fetch_resp       (fetch_resp),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .pfb_rden         (pfb_rden),
        .seq_rd           (seq_rd),
        .ce_execute       (ce_execute),
        .gray_code        (gray_code)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    // Row code after n completed rows, sequence 0 1 3 2
    function automatic logic [1:0] gray_of(input int n);
        logic [1:0] code;
        case (n % 4)
            0: code = 2'b00;
            1: code = 2'b01;
            2: code = 2'b11;
            default: code = 2'b10;
        endcase
        return code;
    endfunction

    task automatic idle_negedges(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Protocol monitor, sampled on the rising edge

    always @(posedge clk) begin
        if (!rst) begin
            // Accept window length
            if (job_accept) begin
                acc_run++;
            end else if (acc_run != 0) begin
                checks++;
                assert (acc_run == quad_ctrl_pkg::JOB_ACCEPT_CYCLES)
                    else report_error($sformatf("accept window of %0d cycles", acc_run));
                acc_run = 0;
            end
            // Fetch request held until ack, dropped right after
            if (prev_ack) begin
                assert (!fetch_req) else report_error("fetch_req still high after ack");
            end
            if (prev_req && !prev_ack) begin
                assert (fetch_req) else report_error("fetch_req dropped before ack");
            end
            if (fetch_req && !prev_req) begin
                assert (!in_progress) else report_error("fetch_req during a fetch");
            end
            if (fetch_resp.ack) in_progress = 1'b1;
            if (fetch_resp.complete) in_progress = 1'b0;
            // Buffer reads per load
            if (fetch_resp.complete) begin
                rd_pulses = 0;
            end else if (pfb_rden) begin
                rd_pulses++;
                assert (rd_pulses <= int'(fetch_resp.full_count))
                    else report_error("more buffer reads than loaded rows");
            end
            // Address walk with wrap at the sequence length
            if (seq_rd.addr != prev_addr) begin
                addr_steps++;
                checks++;
                assert (seq_rd.rden) else report_error("address moved without rden");
                if (int'(prev_addr) == int'(cfg.seq_full_count) - 1) begin
                    assert (seq_rd.addr == '0) else report_error("address did not wrap");
                end else begin
                    assert (seq_rd.addr == prev_addr + 1'b1)
                        else report_error("address did not step by one");
                end
            end
            // Last element lags element 0 by seven cycles
            assert (ce_execute[7] == wave_hist[6])
                else report_error("execute wave bit 7 out of step");
            wave_hist = {wave_hist[5:0], ce_execute[0]};
            // One element 0 pulse per sequence read
            if (ce_execute[0]) begin
                exec_pulses++;
            end
            // Row code follows 0 1 3 2 per row, then clears at job end
            if (gray_code != prev_gray) begin
                if (gray_step < int'(cfg.num_rows)) begin
                    assert (gray_code == gray_of(gray_step + 1))
                        else report_error("gray_code out of sequence");
                    gray_step++;
                end else begin
                    assert (gray_code == 2'b00)
                        else report_error("gray_code not cleared at job end");
                end
            end
            // Completion held until the host answers
            if (prev_done && !prev_cack) begin
                assert (job_complete) else report_error("job_complete dropped before ack");
            end
            prev_req  = fetch_req;
            prev_ack  = fetch_resp.ack;
            prev_done = job_complete;
            prev_cack = job_complete_ack;
            prev_gray = gray_code;
            prev_addr = seq_rd.addr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Loader and host responders

    task automatic serve_fetch();
        idle_negedges($urandom % 4);
        fetch_resp.ack = 1'b1;
        @(negedge clk);
        fetch_resp.ack = 1'b0;
        idle_negedges($urandom % 6);
        fetch_resp.complete = 1'b1;
        @(negedge clk);
        fetch_resp.complete = 1'b0;
    endtask

    task automatic start_job(input int j);
        bit seen;
        seen = 1'b0;
        cfg.num_cols = tab_cols[j];
        cfg.num_rows = tab_rows[j];
        cfg.seq_full_count = tab_seq[j];
        fetch_resp.full_count = tab_pfb[j];
        gray_step = 0;
        addr_steps = 0;
        exec_pulses = 0;
        job_start = 1'b1;
        // Held until the window opens, so a busy DUT just delays the start
        for (int i = 0; i < START_TIMEOUT && !seen; i++) begin
            @(negedge clk);
            seen = job_accept;
        end
        job_start = 1'b0;
        if (!seen) begin
            $display("Timeout: job %0d was never accepted", j);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_job(input int j);
        bit done;
        done = 1'b0;
        for (int i = 0; i < JOB_TIMEOUT && !done; i++) begin
            @(negedge clk);
            if (fetch_req) begin
                serve_fetch();
            end else if (job_complete) begin
                checks++;
                assert (gray_code == 2'b00) else report_error("gray_code not cleared at end");
                assert (gray_step == int'(tab_rows[j]))
                    else report_error($sformatf("job %0d saw %0d row steps", j, gray_step));
                assert (addr_steps == (int'(tab_rows[j]) + 1) * int'(tab_seq[j]))
                    else report_error($sformatf("job %0d saw %0d reads", j, addr_steps));
                assert (exec_pulses == (int'(tab_rows[j]) + 1) * int'(tab_seq[j]))
                    else report_error($sformatf("job %0d saw %0d execute pulses",
                                                j, exec_pulses));
                idle_negedges($urandom % 5);
                job_complete_ack = 1'b1;
                @(negedge clk);
                job_complete_ack = 1'b0;
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("Timeout: job %0d did not complete", j);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(32'h2a551309));
        errors = 0;
        timeouts = 0;
        checks = 0;
        timed_out = 1'b0;
        acc_run = 0;
        rd_pulses = 0;
        addr_steps = 0;
        exec_pulses = 0;
        gray_step = 0;
        in_progress = 1'b0;
        prev_req = 1'b0;
        prev_ack = 1'b0;
        prev_done = 1'b0;
        prev_cack = 1'b0;
        prev_gray = 2'b00;
        prev_addr = '0;
        wave_hist = '0;
        rst = 1'b1;
        job_start = 1'b0;
        cfg = '0;
        fetch_resp = '0;
        job_complete_ack = 1'b0;
        idle_negedges(3);
        // Outputs idle straight out of reset
        assert (!job_accept && !fetch_req && !job_complete && !pfb_rden
                && !seq_rd.rden && ce_execute == '0 && gray_code == 2'b00)
            else report_error("outputs not idle after reset");
        rst = 1'b0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            start_job(j);
            if (timed_out) break;
            run_job(j);
            if (timed_out) break;
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/quad_ctrl_top.sv
`default_nettype none

module quad_ctrl_top (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       job_start,
    output logic                                       job_accept,
    input  quad_ctrl_pkg::job_cfg_t                    cfg,
    output logic                                       fetch_req,
    input  quad_ctrl_pkg::fetch_resp_t                 fetch_resp,
    output logic                                       job_complete,
    input  logic                                       job_complete_ack,
    output logic                                       pfb_rden,
    output quad_ctrl_pkg::seq_rd_t                     seq_rd,
    output logic [quad_ctrl_pkg::CE_EXEC_W-1:0]        ce_execute,
    output logic [1:0]                                 gray_code
);

    // Prefetch buffer status
    quad_ctrl_pkg::pfb_cnt_t pfb_count;
    quad_ctrl_pkg::coord_t   input_row;
    logic                    pfb_full_count_seen;

    // Sequencer strobes
    logic prime_rden_en;
    logic seq_run;
    logic seq_reload;

    // Sequence read side
    logic                    seq_strobe;
    quad_ctrl_pkg::seq_cnt_t seq_count;
    logic                    ce_busy;
    logic                    row_end;
    logic                    job_end;

    // Buffer holds exactly one fresh load
    assign pfb_full_count_seen = (pfb_count == fetch_resp.full_count);

    job_sequencer u_job_sequencer (
        .clk                 (clk),
        .rst                 (rst),
        .job_start           (job_start),
        .job_accept          (job_accept),
        .cfg                 (cfg),
        .fetch_req           (fetch_req),
        .fetch_resp          (fetch_resp),
        .job_complete        (job_complete),
        .job_complete_ack    (job_complete_ack),
        .pfb_count           (pfb_count),
        .input_row           (input_row),
        .pfb_full_count_seen (pfb_full_count_seen),
        .row_end             (row_end),
        .job_end             (job_end),
        .ce_busy             (ce_busy),
        .seq_count           (seq_count),
        .prime_rden_en       (prime_rden_en),
        .seq_run             (seq_run),
        .seq_reload          (seq_reload),
        .gray_code           (gray_code)
    );

    // Input column is not consumed at this level
    pfb_reader u_pfb_reader (
        .clk           (clk),
        .rst           (rst),
        .prime_rden_en (prime_rden_en),
        .fetch_resp    (fetch_resp),
        .pfb_rden      (pfb_rden),
        .pfb_count     (pfb_count),
        .input_row     (input_row),
        .input_col     (),
        .cfg           (cfg)
    );

    pix_seq_reader u_pix_seq_reader (
        .clk        (clk),
        .rst        (rst),
        .seq_run    (seq_run),
        .seq_reload (seq_reload),
        .cfg        (cfg),
        .seq_rd     (seq_rd),
        .seq_strobe (seq_strobe),
        .seq_count  (seq_count),
        .ce_busy    (ce_busy),
        .ce_execute (ce_execute)
    );

    output_tracker u_output_tracker (
        .clk        (clk),
        .rst        (rst),
        .seq_strobe (seq_strobe),
        .cfg        (cfg),
        .row_end    (row_end),
        .job_end    (job_end)
    );

endmodule

`default_nettype wire

// File: hw/output_tracker.sv
`default_nettype none

module output_tracker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     seq_strobe,
    input  quad_ctrl_pkg::job_cfg_t  cfg,
    output logic                     row_end,
    output logic                     job_end
);

    // Reads into the current pixel
    logic [$clog2(quad_ctrl_pkg::READS_PER_PIXEL)-1:0] rd_cnt;
    quad_ctrl_pkg::coord_t                             out_col;
    quad_ctrl_pkg::coord_t                             out_row;

    // Whole last pixel of a row, last row for the job
    assign row_end = (out_col == cfg.num_cols);
    assign job_end = row_end && (out_row == cfg.num_rows);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cnt  <= '0;
            out_col <= '0;
            out_row <= '0;
        end else if (seq_strobe) begin
            if (int'(rd_cnt) == quad_ctrl_pkg::READS_PER_PIXEL - 1) begin
                rd_cnt <= '0;
                if (row_end) begin
                    out_col <= '0;
                    // Back to row 0 for the next job
                    out_row <= job_end ? '0 : out_row + 1'b1;
                end else begin
                    out_col <= out_col + 1'b1;
                end
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/pix_seq_reader.sv
`default_nettype none

module pix_seq_reader (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   seq_run,
    input  logic                                   seq_reload,
    input  quad_ctrl_pkg::job_cfg_t                cfg,
    output quad_ctrl_pkg::seq_rd_t                 seq_rd,
    output logic                                   seq_strobe,
    output quad_ctrl_pkg::seq_cnt_t                seq_count,
    output logic                                   ce_busy,
    output logic [quad_ctrl_pkg::CE_EXEC_W-1:0]    ce_execute
);

    quad_ctrl_pkg::seq_addr_t rd_addr;
    quad_ctrl_pkg::seq_addr_t addr_last;

    // Strobe history for the enable stretch
    logic [quad_ctrl_pkg::SEQ_RDEN_STRETCH-1:0] rden_hist;
    // Covers the BRAM read latency
    logic [quad_ctrl_pkg::SEQ_EXEC_DELAY-1:0]   exec_dly;

    assign addr_last = quad_ctrl_pkg::seq_addr_t'(cfg.seq_full_count) - 1'b1;

    // Enable stays up while any recent strobe is still in the BRAM
    assign seq_rd.rden = seq_strobe | (|rden_hist);
    assign seq_rd.addr = rd_addr;

    // Array busy while any element still has a wave bit
    assign ce_busy = |ce_execute;

    ////////////////////////////////////////////////////////////////////////////
    // Read strobe, count and address

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_strobe <= 1'b0;
            seq_count  <= '0;
            rd_addr    <= '0;
        end else begin
            // Registered strobe lags the count by one
            seq_strobe <= seq_run && (seq_count > 1);
            if (seq_reload) begin
                seq_count <= cfg.seq_full_count;
                rd_addr   <= '0;
            end else if (seq_strobe) begin
                seq_count <= seq_count - 1'b1;
                if (rd_addr == addr_last) begin
                    rd_addr <= '0;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Enable stretch and execute wave

    always_ff @(posedge clk) begin
        if (rst) begin
            rden_hist  <= '0;
            exec_dly   <= '0;
            ce_execute <= '0;
        end else begin
            rden_hist <= {rden_hist[quad_ctrl_pkg::SEQ_RDEN_STRETCH-2:0], seq_strobe};
            exec_dly  <= {exec_dly[quad_ctrl_pkg::SEQ_EXEC_DELAY-2:0], seq_strobe};
            // Element k fires k cycles after element 0
            ce_execute <= {ce_execute[quad_ctrl_pkg::CE_EXEC_W-2:0],
                           exec_dly[quad_ctrl_pkg::SEQ_EXEC_DELAY-1]};
        end
    end

endmodule

`default_nettype wire

// File: hw/pfb_reader.sv
`default_nettype none

module pfb_reader (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        prime_rden_en,
    input  quad_ctrl_pkg::fetch_resp_t  fetch_resp,
    output logic                        pfb_rden,
    output quad_ctrl_pkg::pfb_cnt_t     pfb_count,
    output quad_ctrl_pkg::coord_t       input_row,
    output quad_ctrl_pkg::coord_t       input_col,
    input  quad_ctrl_pkg::job_cfg_t     cfg
);

    logic prime_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            prime_q   <= 1'b0;
            pfb_rden  <= 1'b0;
            pfb_count <= '0;
            input_row <= '0;
            input_col <= '0;
        end else begin
            prime_q <= prime_rden_en;
            if (prime_rden_en && !prime_q) begin
                // New job restarts the input position
                pfb_rden  <= 1'b0;
                pfb_count <= '0;
                input_row <= '0;
                input_col <= '0;
            end else begin
                // One read in flight, so stop issuing at a count of 1
                pfb_rden <= prime_rden_en && (pfb_count > 1);

                // Occupancy
                if (fetch_resp.complete) begin
                    pfb_count <= fetch_resp.full_count;
                end else if (pfb_rden) begin
                    pfb_count <= pfb_count - 1'b1;
                end

                // Input position, num_cols is the last column
                if (pfb_rden) begin
                    if (input_col == cfg.num_cols) begin
                        input_col <= '0;
                        input_row <= input_row + 1'b1;
                    end else begin
                        input_col <= input_col + 1'b1;
                    end
                end
            end
        end
    end

    // Strobe pipeline never overruns the buffer
    a_rden_nonempty: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> (pfb_count != '0));

endmodule

`default_nettype wire

// File: hw/job_sequencer.sv
`default_nettype none

module job_sequencer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        job_start,
    output logic                        job_accept,
    input  quad_ctrl_pkg::job_cfg_t     cfg,
    output logic                        fetch_req,
    input  quad_ctrl_pkg::fetch_resp_t  fetch_resp,
    output logic                        job_complete,
    input  logic                        job_complete_ack,
    input  quad_ctrl_pkg::pfb_cnt_t     pfb_count,
    input  quad_ctrl_pkg::coord_t       input_row,
    input  logic                        pfb_full_count_seen,
    input  logic                        row_end,
    input  logic                        job_end,
    input  logic                        ce_busy,
    input  quad_ctrl_pkg::seq_cnt_t     seq_count,
    output logic                        prime_rden_en,
    output logic                        seq_run,
    output logic                        seq_reload,
    output logic [1:0]                  gray_code
);

    quad_ctrl_pkg::seq_state_t state;
    quad_ctrl_pkg::seq_state_t return_state;
    quad_ctrl_pkg::seq_state_t next_state;

    logic [quad_ctrl_pkg::JOB_ACCEPT_CYCLES-1:0] accept_sr;
    logic                                        fetch_acked;
    logic                                        complete_acked;
    logic [1:0]                                  gray_cnt;

    quad_ctrl_pkg::coord_t prime_last;
    logic                  go_active;
    logic                  commit;

    ////////////////////////////////////////////////////////////////////////////
    // Phase decisions

    // Short maps finish priming early
    assign prime_last = (cfg.num_rows < quad_ctrl_pkg::coord_t'(quad_ctrl_pkg::PRIME_ROWS - 1))
                      ? cfg.num_rows
                      : quad_ctrl_pkg::coord_t'(quad_ctrl_pkg::PRIME_ROWS - 1);

    // Last prime row sitting freshly loaded in the buffer
    assign go_active = (state == quad_ctrl_pkg::ST_PRIME) && (input_row >= prime_last)
                    && pfb_full_count_seen;

    // Row fully drained from the sequence side and the array
    assign commit = (state == quad_ctrl_pkg::ST_ACTIVE) && !ce_busy && (seq_count == '0);

    // Held through prime refills so the reader sees one rising edge per job
    assign prime_rden_en = ((state == quad_ctrl_pkg::ST_PRIME) && !go_active)
                        || ((state == quad_ctrl_pkg::ST_WAIT_LOAD)
                            && (return_state == quad_ctrl_pkg::ST_PRIME));

    assign seq_run    = (state == quad_ctrl_pkg::ST_ACTIVE);
    assign seq_reload = go_active || commit;
    assign job_accept = |accept_sr;

    // Binary to gray
    assign gray_code = {gray_cnt[1], gray_cnt[1] ^ gray_cnt[0]};

    ////////////////////////////////////////////////////////////////////////////
    // Job FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= quad_ctrl_pkg::ST_IDLE;
            return_state   <= quad_ctrl_pkg::ST_IDLE;
            next_state     <= quad_ctrl_pkg::ST_WAIT_LOAD;
            accept_sr      <= '0;
            fetch_req      <= 1'b0;
            fetch_acked    <= 1'b0;
            job_complete   <= 1'b0;
            complete_acked <= 1'b0;
            gray_cnt       <= 2'b00;
        end else begin
            // Accept window opens the cycle after the start
            accept_sr <= {accept_sr[quad_ctrl_pkg::JOB_ACCEPT_CYCLES-2:0],
                          (state == quad_ctrl_pkg::ST_IDLE) && job_start};
            unique case (state)
                quad_ctrl_pkg::ST_IDLE: begin
                    // Empty buffer, first load goes straight out
                    if (job_start) begin
                        return_state <= quad_ctrl_pkg::ST_PRIME;
                        state        <= quad_ctrl_pkg::ST_WAIT_LOAD;
                    end
                end
                quad_ctrl_pkg::ST_WAIT_LOAD: begin
                    // Request held until ack, then wait for complete
                    if (fetch_resp.ack) begin
                        fetch_req   <= 1'b0;
                        fetch_acked <= 1'b1;
                    end else if (!fetch_acked) begin
                        fetch_req <= 1'b1;
                    end
                    if (fetch_resp.complete && fetch_acked) begin
                        fetch_acked <= 1'b0;
                        state       <= return_state;
                    end
                end
                quad_ctrl_pkg::ST_PRIME: begin
                    if (go_active) begin
                        state <= quad_ctrl_pkg::ST_ACTIVE;
                    end else if (pfb_count == '0) begin
                        // Buffer dry before the prime window is full
                        return_state <= quad_ctrl_pkg::ST_PRIME;
                        state        <= quad_ctrl_pkg::ST_WAIT_LOAD;
                    end
                end
                quad_ctrl_pkg::ST_ACTIVE: begin
                    // Latched during the last pixel of the row
                    if (job_end) begin
                        next_state <= quad_ctrl_pkg::ST_DONE;
                    end else if (row_end) begin
                        next_state <= quad_ctrl_pkg::ST_WAIT_LOAD;
                    end
                    if (commit) begin
                        state        <= next_state;
                        return_state <= quad_ctrl_pkg::ST_ACTIVE;
                        if (next_state == quad_ctrl_pkg::ST_DONE) begin
                            gray_cnt <= 2'b00;
                        end else begin
                            gray_cnt <= gray_cnt + 1'b1;
                        end
                    end
                end
                quad_ctrl_pkg::ST_DONE: begin
                    // Completion held until the host answers
                    job_complete <= !job_complete_ack && !complete_acked;
                    if (job_complete_ack) begin
                        complete_acked <= 1'b1;
                    end
                    if (complete_acked) begin
                        complete_acked <= 1'b0;
                        state          <= quad_ctrl_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= quad_ctrl_pkg::ST_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    // Encoding stays legal across every transition
    a_state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state));

    // No request while the loader still owns the buffer
    a_fetch_exclusive: assert property (@(posedge clk) disable iff (rst)
        fetch_acked |-> !fetch_req);

endmodule

`default_nettype wire

// File: hw/quad_ctrl_pkg.sv
`default_nettype none

package quad_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    // One buffer BRAM
    localparam int BRAM_DEPTH = 1024;
    // Row and column coordinates address half a BRAM
    localparam int COORD_W = $clog2(BRAM_DEPTH) - 1;
    localparam int PFB_CNT_W = 9;
    localparam int SEQ_CNT_W = 11;
    localparam int SEQ_ADDR_W = 12;

    // Compute array shape
    localparam int NUM_AWE = 4;
    localparam int NUM_CE_PER_AWE = 2;
    localparam int CE_EXEC_W = NUM_AWE * NUM_CE_PER_AWE;

    // Pipeline and handshake timing
    localparam int READS_PER_PIXEL = 5;
    localparam int PRIME_ROWS = 4;
    // Sequence BRAM read latency ahead of execute
    localparam int SEQ_EXEC_DELAY = 2;
    localparam int SEQ_RDEN_STRETCH = 3;
    localparam int JOB_ACCEPT_CYCLES = 5;

    ////////////////////////////////////////////////////////////////////////////
    // Types

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [PFB_CNT_W-1:0] pfb_cnt_t;
    typedef logic [SEQ_CNT_W-1:0] seq_cnt_t;
    typedef logic [SEQ_ADDR_W-1:0] seq_addr_t;

    // One-hot job states
    typedef enum logic [4:0] {
        ST_IDLE      = 5'b00001,
        ST_PRIME     = 5'b00010,
        ST_WAIT_LOAD = 5'b00100,
        ST_ACTIVE    = 5'b01000,
        ST_DONE      = 5'b10000
    } seq_state_t;

    // Map sizes are given as last index, not count
    typedef struct packed {
        coord_t   num_cols;
        coord_t   num_rows;
        seq_cnt_t seq_full_count;
    } job_cfg_t;

    // Loader answer to a fetch request
    typedef struct packed {
        logic     ack;
        logic     complete;
        pfb_cnt_t full_count;
    } fetch_resp_t;

    typedef struct packed {
        logic      rden;
        seq_addr_t addr;
    } seq_rd_t;

endpackage

`default_nettype wire
